/* include/addr_params.svh */
`ifndef ADDR_PARAMS_SVH
`define ADDR_PARAMS_SVH

// Width of a byte address on the data side
// The cache geometry in cache_pkg is derived from it
`define ALEN 15

`endif

/* hdl/cache_pkg.sv */
`default_nettype none

`include "addr_params.svh"

package cache_pkg;

    // One cache word is a 64-bit aligned doubleword
    localparam int data_size = 64;
    localparam int align_bits = $clog2(data_size / 8);

    // Word addresses drop the byte offset
    localparam int aligned_addr_size = `ALEN - align_bits;

    typedef logic [aligned_addr_size-1:0] word_addr_t;

    // Request from outside, a read when write is low
    typedef struct packed {
        logic                 write;
        word_addr_t           addr;
        logic [data_size-1:0] wdata;
    } cache_req_t;

    // Read response, hit is low when the word came from a refill
    typedef struct packed {
        logic [data_size-1:0] data;
        logic                 hit;
    } cache_resp_t;

endpackage

`default_nettype wire

/* hdl/line_cache.sv */
`timescale 1ns/1ns
`default_nettype none

// Direct-mapped line store, one word per row
// Each row holds the tag next to the data, row layout is | tag | data |
module line_cache #(
    parameter int index_bits = 6
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          write_enable,
    input  wire cache_pkg::word_addr_t   waddr,
    input  wire [cache_pkg::data_size-1:0] wdata,
    input  wire cache_pkg::word_addr_t   raddr,
    output logic [cache_pkg::data_size-1:0] rdata,
    output logic                         lookup_valid
);

    localparam int tag_bits = cache_pkg::aligned_addr_size - index_bits;
    localparam int rows = 1 << index_bits;

    typedef struct packed {
        logic [tag_bits-1:0]            tag;
        logic [cache_pkg::data_size-1:0] data;
    } entry_t;

    entry_t mem [rows];
    logic [rows-1:0] valid_bits;

    logic [index_bits-1:0] w_index;
    logic [index_bits-1:0] r_index;
    logic [tag_bits-1:0]   r_tag;
    entry_t                w_entry;

    // Registered side of the lookup
    entry_t                read_buf;
    entry_t                write_buf;
    logic [tag_bits-1:0]   last_tag;
    logic [index_bits-1:0] last_index;
    logic                  read_from_write;

    entry_t                cur_entry;

    // Split both addresses into row index and tag
    always_comb begin
        w_index = waddr[index_bits-1:0];
        w_entry.tag = waddr[cache_pkg::aligned_addr_size-1 -: tag_bits];
        w_entry.data = wdata;

        r_index = raddr[index_bits-1:0];
        r_tag = raddr[cache_pkg::aligned_addr_size-1 -: tag_bits];
    end

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[w_index] <= w_entry;
        end
    end

    // Row read and the address it belongs to, compared a cycle later
    always_ff @(posedge clk) begin
        read_buf <= mem[r_index];
        last_tag <= r_tag;
        last_index <= r_index;
        if (write_enable) begin
            write_buf <= w_entry;
        end
    end

    // The memory read above still returns the old row when the same row is
    // written at this edge, so remember to take the written entry instead
    always_ff @(posedge clk) begin
        if (rst) begin
            read_from_write <= 1'b0;
        end else begin
            read_from_write <= write_enable && (r_index == w_index);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (write_enable) begin
            valid_bits[w_index] <= 1'b1;
        end
    end

    // Late tag compare on the registered row
    always_comb begin
        if (read_from_write) begin
            cur_entry = write_buf;
        end else begin
            cur_entry = read_buf;
        end
        rdata = cur_entry.data;
        lookup_valid = valid_bits[last_index] && (cur_entry.tag == last_tag);
    end

endmodule

`default_nettype wire

/* hdl/load_front.sv */
`timescale 1ns/1ns
`default_nettype none

// Request side of the data memory path
// Reads look up the cache, writes go to the cache and through to the store
module load_front #(
    parameter int index_bits = 6
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            req_valid,
    input  wire cache_pkg::cache_req_t     req,
    output logic                           busy,
    output logic                           resp_valid,
    output cache_pkg::cache_resp_t         resp,
    output cache_pkg::word_addr_t          cache_raddr,
    output logic                           cache_we,
    output cache_pkg::word_addr_t          cache_waddr,
    output logic [cache_pkg::data_size-1:0] cache_wdata,
    input  wire [cache_pkg::data_size-1:0] cache_rdata,
    input  wire                            lookup_valid,
    output logic                           store_strobe,
    output cache_pkg::cache_req_t          store_req,
    output logic                           miss_strobe,
    output cache_pkg::word_addr_t          miss_addr,
    input  wire                            fill_done,
    input  wire [cache_pkg::data_size-1:0] fill_data
);

    // The tag has to keep at least one bit of the word address
    if (index_bits >= cache_pkg::aligned_addr_size) begin : g_geometry_check
        $error("index_bits leaves no room for a tag");
    end

    logic                  accept;
    logic                  pending;
    logic                  missing;
    logic                  lookup_miss;
    cache_pkg::word_addr_t pend_addr;

    always_comb begin
        accept = req_valid && !busy;
        lookup_miss = pending && !lookup_valid;
        // Busy rises in the lookup cycle of a miss and holds through fill_done
        busy = missing || lookup_miss;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            missing <= 1'b0;
        end else begin
            pending <= accept && !req.write;
            if (lookup_miss) begin
                missing <= 1'b1;
            end else if (fill_done) begin
                missing <= 1'b0;
            end
        end
    end

    // Address of the read in flight, held while its refill runs
    always_ff @(posedge clk) begin
        if (accept && !req.write) begin
            pend_addr <= req.addr;
        end
    end

    assign cache_raddr = req.addr;

    // Single write port, refills only land while busy blocks new writes
    always_comb begin
        cache_we = (accept && req.write) || fill_done;
        if (fill_done) begin
            cache_waddr = pend_addr;
            cache_wdata = fill_data;
        end else begin
            cache_waddr = req.addr;
            cache_wdata = req.wdata;
        end
    end

    assign store_strobe = accept && req.write;
    assign store_req = req;

    assign miss_strobe = lookup_miss;
    assign miss_addr = pend_addr;

    always_comb begin
        resp_valid = (pending && lookup_valid) || fill_done;
        resp.hit = !fill_done;
        resp.data = fill_done ? fill_data : cache_rdata;
    end

endmodule

`default_nettype wire

/* hdl/backing_store.sv */
`timescale 1ns/1ns
`default_nettype none

// Word RAM behind the cache with a fixed read latency
module backing_store #(
    parameter int fill_latency = 4
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            we,
    input  wire cache_pkg::word_addr_t     waddr,
    input  wire [cache_pkg::data_size-1:0] wdata,
    input  wire                            rd_strobe,
    input  wire cache_pkg::word_addr_t     rd_addr,
    output logic                           rd_valid,
    output logic [cache_pkg::data_size-1:0] rd_data
);

    localparam int words = 1 << cache_pkg::aligned_addr_size;

    logic [cache_pkg::data_size-1:0] mem [words];

    logic [fill_latency-1:0]         vld_pipe;
    logic [cache_pkg::data_size-1:0] data_pipe [fill_latency];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Stage 0 samples the RAM, later stages only delay the word
    always_ff @(posedge clk) begin
        data_pipe[0] <= mem[rd_addr];
        for (int i = 1; i < fill_latency; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= rd_strobe;
            for (int i = 1; i < fill_latency; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    assign rd_valid = vld_pipe[fill_latency-1];
    assign rd_data = data_pipe[fill_latency-1];

endmodule

`default_nettype wire

/* hdl/miss_refill.sv */
`timescale 1ns/1ns
`default_nettype none

// Refill engine and write-through path in front of the backing store
// Only one refill is outstanding at a time
module miss_refill #(
    parameter int fill_latency = 4
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            store_strobe,
    input  wire cache_pkg::cache_req_t     store_req,
    input  wire                            miss_strobe,
    input  wire cache_pkg::word_addr_t     miss_addr,
    output logic                           fill_done,
    output logic [cache_pkg::data_size-1:0] fill_data
);

    logic                            active;
    logic                            launch;
    logic                            rd_strobe;
    cache_pkg::word_addr_t           rd_addr;
    logic                            rd_valid;
    logic [cache_pkg::data_size-1:0] rd_data;
    logic                            store_we;

    // A miss that arrives while a refill runs is dropped
    assign launch = miss_strobe && !active;

    assign store_we = store_strobe && store_req.write;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            rd_strobe <= 1'b0;
        end else begin
            rd_strobe <= launch;
            if (launch) begin
                active <= 1'b1;
            end else if (rd_valid) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            rd_addr <= miss_addr;
        end
    end

    // The registered launch adds one cycle ahead of the store latency
    assign fill_done = rd_valid && active;
    assign fill_data = rd_data;

    backing_store #(
        .fill_latency(fill_latency)
    ) store0 (
        .clk      (clk),
        .rst      (rst),
        .we       (store_we),
        .waddr    (store_req.addr),
        .wdata    (store_req.wdata),
        .rd_strobe(rd_strobe),
        .rd_addr  (rd_addr),
        .rd_valid (rd_valid),
        .rd_data  (rd_data)
    );

endmodule

`default_nettype wire

/* hdl/mem_subsys.sv */
`timescale 1ns/1ns
`default_nettype none

// Data-side memory path: request front, line cache and refill unit
module mem_subsys #(
    parameter int index_bits = 6,
    parameter int fill_latency = 4
) (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        req_valid,
    input  wire cache_pkg::cache_req_t req,
    output logic                       busy,
    output logic                       resp_valid,
    output cache_pkg::cache_resp_t     resp
);

    cache_pkg::word_addr_t           cache_raddr;
    logic                            cache_we;
    cache_pkg::word_addr_t           cache_waddr;
    logic [cache_pkg::data_size-1:0] cache_wdata;
    logic [cache_pkg::data_size-1:0] cache_rdata;
    logic                            lookup_valid;

    logic                            store_strobe;
    cache_pkg::cache_req_t           store_req;
    logic                            miss_strobe;
    cache_pkg::word_addr_t           miss_addr;
    logic                            fill_done;
    logic [cache_pkg::data_size-1:0] fill_data;

    load_front #(
        .index_bits(index_bits)
    ) front0 (
        .clk         (clk),
        .rst         (rst),
        .req_valid   (req_valid),
        .req         (req),
        .busy        (busy),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .cache_raddr (cache_raddr),
        .cache_we    (cache_we),
        .cache_waddr (cache_waddr),
        .cache_wdata (cache_wdata),
        .cache_rdata (cache_rdata),
        .lookup_valid(lookup_valid),
        .store_strobe(store_strobe),
        .store_req   (store_req),
        .miss_strobe (miss_strobe),
        .miss_addr   (miss_addr),
        .fill_done   (fill_done),
        .fill_data   (fill_data)
    );

    line_cache #(
        .index_bits(index_bits)
    ) cache0 (
        .clk         (clk),
        .rst         (rst),
        .write_enable(cache_we),
        .waddr       (cache_waddr),
        .wdata       (cache_wdata),
        .raddr       (cache_raddr),
        .rdata       (cache_rdata),
        .lookup_valid(lookup_valid)
    );

    miss_refill #(
        .fill_latency(fill_latency)
    ) refill0 (
        .clk         (clk),
        .rst         (rst),
        .store_strobe(store_strobe),
        .store_req   (store_req),
        .miss_strobe (miss_strobe),
        .miss_addr   (miss_addr),
        .fill_done   (fill_done),
        .fill_data   (fill_data)
    );

endmodule

`default_nettype wire

/* verification/mem_subsys_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_assertions (
    input wire clk,
    input wire rst,
    input wire req_valid,
    input wire busy,
    input wire resp_valid,
    input wire resp_hit,
    input wire miss_strobe,
    input wire fill_done,
    input wire cache_we
);

    logic accept;

    assign accept = req_valid && !busy;

    // A hit answers exactly one accepted read
    hit_resp_single: assert property (@(posedge clk) disable iff (rst)
        (resp_valid && resp_hit && !accept) |=> !(resp_valid && resp_hit))
        else $error("hit response repeated without a new accepted read");

    miss_fill_apart: assert property (@(posedge clk) disable iff (rst)
        !(miss_strobe && fill_done))
        else $error("miss_strobe and fill_done high in the same cycle");

    // The write port belongs to the refill while busy and to requests otherwise
    no_write_when_busy: assert property (@(posedge clk) disable iff (rst)
        cache_we |-> (fill_done == busy))
        else $error("cache write port used by a request while busy or by a refill while idle");

endmodule

bind load_front mem_subsys_assertions asrt0 (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .busy       (busy),
    .resp_valid (resp_valid),
    .resp_hit   (resp.hit),
    .miss_strobe(miss_strobe),
    .fill_done  (fill_done),
    .cache_we   (cache_we)
);

`default_nettype wire

/* verification/mem_subsys_checker.sv */
`timescale 1ns/1ns
`default_nettype none

// Compares every read response with the next expected one in order
module mem_subsys_checker (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            exp_push,
    input  wire [cache_pkg::data_size-1:0] exp_data,
    input  wire                            exp_hit,
    input  wire                            resp_valid,
    input  wire cache_pkg::cache_resp_t    resp,
    output int                             error_count,
    output int                             outstanding
);

    cache_pkg::cache_resp_t expect_q [$];
    cache_pkg::cache_resp_t expected;
    cache_pkg::cache_resp_t incoming;
    int                     errors = 0;

    always @(posedge clk) begin
        if (!rst && resp_valid) begin
            if (expect_q.size() == 0) begin
                $display("Time %0t: a read response arrived with no read outstanding",
                         $time);
                errors++;
            end else begin
                expected = expect_q.pop_front();
                if (resp.data !== expected.data) begin
                    $display("FAIL time %0t resp.data expected %h actual %h",
                             $time, expected.data, resp.data);
                    errors++;
                end
                if (resp.hit !== expected.hit) begin
                    $display("FAIL time %0t resp.hit expected %0b actual %0b",
                             $time, expected.hit, resp.hit);
                    errors++;
                end
            end
        end
        // The read is accepted at this edge, its response comes later
        if (!rst && exp_push) begin
            incoming.data = exp_data;
            incoming.hit = exp_hit;
            expect_q.push_back(incoming);
        end
    end

    assign error_count = errors;
    assign outstanding = expect_q.size();

endmodule

`default_nettype wire

/* verification/mem_subsys_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_tb;

    localparam int fill_latency = 4;
    localparam int max_ops = 64;
    localparam string op_file = "verification/mem_ops_input.txt";

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   req_valid;
    cache_pkg::cache_req_t  req;
    logic                   busy;
    logic                   resp_valid;
    cache_pkg::cache_resp_t resp;

    logic                            exp_push;
    logic [cache_pkg::data_size-1:0] exp_data;
    logic                            exp_hit;
    int                              checker_errors;
    int                              outstanding;

    // Operation table where kind 0 is a write, 1 a read and 2 a read with a stray strobe
    logic [3:0]                      op_kind [max_ops];
    cache_pkg::word_addr_t           op_addr [max_ops];
    logic [cache_pkg::data_size-1:0] op_wdata [max_ops];
    logic [cache_pkg::data_size-1:0] op_exp_data [max_ops];
    logic                            op_exp_hit [max_ops];
    int                              op_count = 0;

    int driver_errors = 0;
    int cycle_count = 0;
    int cycle_limit = 100000;

    always #2 clk = ~clk;

    mem_subsys #(
        .index_bits  (6),
        .fill_latency(fill_latency)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .resp_valid(resp_valid),
        .resp      (resp)
    );

    mem_subsys_checker chk0 (
        .clk        (clk),
        .rst        (rst),
        .exp_push   (exp_push),
        .exp_data   (exp_data),
        .exp_hit    (exp_hit),
        .resp_valid (resp_valid),
        .resp       (resp),
        .error_count(checker_errors),
        .outstanding(outstanding)
    );

    task automatic load_ops();
        int fd;
        int fields;
        string line;
        logic [3:0] kind;
        cache_pkg::word_addr_t addr;
        logic [cache_pkg::data_size-1:0] wdata;
        logic [cache_pkg::data_size-1:0] edata;
        logic ehit;
        fd = $fopen(op_file, "r");
        if (fd == 0) begin
            $display("Cannot open the operation file %s", op_file);
        end else begin
            while (!$feof(fd) && op_count < max_ops) begin
                line = "";
                if ($fgets(line, fd) != 0 && line.len() > 0 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h", kind, addr, wdata, edata, ehit);
                    if (fields == 5) begin
                        op_kind[op_count] = kind;
                        op_addr[op_count] = addr;
                        op_wdata[op_count] = wdata;
                        op_exp_data[op_count] = edata;
                        op_exp_hit[op_count] = ehit;
                        op_count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // All driving tasks start and end 1 ns after a rising edge
    task automatic wait_idle();
        while (busy) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_response();
        while (!resp_valid) begin
            @(posedge clk);
            #1;
        end
    endtask

    // A read of a neighbouring word while the refill runs has to be ignored
    task automatic drive_stray(input cache_pkg::word_addr_t addr);
        if (!busy) begin
            $display("Time %0t: busy stayed low after a read that should miss", $time);
            driver_errors++;
        end else begin
            req_valid = 1'b1;
            req.write = 1'b0;
            req.addr = addr ^ cache_pkg::word_addr_t'(1);
            req.wdata = '0;
            @(posedge clk);
            #1;
            req_valid = 1'b0;
        end
    endtask

    task automatic send_op(input int idx);
        wait_idle();
        req_valid = 1'b1;
        req.write = (op_kind[idx] == 4'd0);
        req.addr = op_addr[idx];
        req.wdata = op_wdata[idx];
        exp_push = (op_kind[idx] != 4'd0);
        exp_data = op_exp_data[idx];
        exp_hit = op_exp_hit[idx];
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        exp_push = 1'b0;
        if (op_kind[idx] == 4'd2) begin
            drive_stray(op_addr[idx]);
        end
        if (op_kind[idx] != 4'd0) begin
            wait_response();
        end
    endtask

    initial begin : main_flow
        int idx;
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        exp_push = 1'b0;
        exp_data = '0;
        exp_hit = 1'b0;
        load_ops();
        // A read miss takes about fill_latency plus 4 cycles from drive to idle
        cycle_limit = op_count * (fill_latency + 4) + 20;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        if (op_count == 0) begin
            $display("No operations were read from %s", op_file);
            driver_errors++;
        end
        for (idx = 0; idx < op_count; idx++) begin
            send_op(idx);
        end
        // Leave room for a response that should not come
        repeat (fill_latency + 4) @(posedge clk);
        #1;
        if (outstanding != 0) begin
            $display("%0d expected read responses never arrived", outstanding);
            driver_errors++;
        end
        $display("Errors: checker %0d, driver %0d", checker_errors, driver_errors);
        if (checker_errors == 0 && driver_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin : watchdog
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, errors: checker %0d, driver %0d",
                 cycle_count, checker_errors, driver_errors);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verification/mem_ops_input.txt */
# kind (0 write, 1 read, 2 read with stray strobe) word_addr wdata expected_data expected_hit
# Word address bits [5:0] select the cache row, bits [11:6] are the tag
0 005 1111111111111111 0000000000000000 0
0 00a 2222222222222222 0000000000000000 0
1 005 0000000000000000 1111111111111111 1
0 010 3333333333333333 0000000000000000 0
1 010 0000000000000000 3333333333333333 1
0 020 aaaaaaaaaaaaaaaa 0000000000000000 0
0 060 bbbbbbbbbbbbbbbb 0000000000000000 0
1 020 0000000000000000 aaaaaaaaaaaaaaaa 0
1 020 0000000000000000 aaaaaaaaaaaaaaaa 1
1 060 0000000000000000 bbbbbbbbbbbbbbbb 0
1 060 0000000000000000 bbbbbbbbbbbbbbbb 1
0 060 cccccccccccccccc 0000000000000000 0
1 060 0000000000000000 cccccccccccccccc 1
1 020 0000000000000000 aaaaaaaaaaaaaaaa 0
1 060 0000000000000000 cccccccccccccccc 0
1 060 0000000000000000 cccccccccccccccc 1
0 125 dddddddddddddddd 0000000000000000 0
0 0e5 eeeeeeeeeeeeeeee 0000000000000000 0
2 125 0000000000000000 dddddddddddddddd 0
1 125 0000000000000000 dddddddddddddddd 1
0 fff 0123456789abcdef 0000000000000000 0
1 fff 0000000000000000 0123456789abcdef 1
0 03f fedcba9876543210 0000000000000000 0
1 fff 0000000000000000 0123456789abcdef 0
2 03f 0000000000000000 fedcba9876543210 0
1 03f 0000000000000000 fedcba9876543210 1

/* verilog.f */
+incdir+include
hdl/cache_pkg.sv
hdl/line_cache.sv
hdl/load_front.sv
hdl/backing_store.sv
hdl/miss_refill.sv
hdl/mem_subsys.sv
verification/mem_subsys_assertions.sv
verification/mem_subsys_checker.sv
verification/mem_subsys_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module mem_subsys_tb \
    -f verilog.f

out=$(./obj_dir/Vmem_subsys_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'All checks passed'; then
    exit 0
fi
exit 1
